// File: common/rv32i_pkg.sv
/*
  RV32I shared definitions
  Widths, opcode and funct3 encodings, ALU operations, instruction
  field views and the control and handshake items that travel
  between the decoder, the register file and the execute stage.
*/

`default_nettype none

package rv32i_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 5;

  // Base opcodes, instr[6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    IMMED  = 7'b0010011,
    REGREG = 7'b0110011
  } opcode_t;

  typedef enum logic [2:0] {
    ADDSUB = 3'b000,
    SLL    = 3'b001,
    SLT    = 3'b010,
    SLTU   = 3'b011,
    XOR    = 3'b100,
    SR     = 3'b101,
    OR     = 3'b110,
    AND    = 3'b111
  } alu_funct3_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  // Stores share the size encoding of LB/LH/LW
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_t;

  // Instruction format views
  typedef struct packed {
    logic [11:0] imm11_00;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0] imm11_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm04_00;
    opcode_t    opcode;
  } stype_t;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } rtype_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm04_01;
    logic       imm11;
    opcode_t    opcode;
  } sbtype_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
  } utype_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_01;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } ujtype_t;

  typedef enum logic [1:0] {A_RS1, A_PC} a_sel_t;
  typedef enum logic [1:0] {B_RS2, B_IMM} b_sel_t;
  typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_UIMM} wb_sel_t;

  typedef struct packed {
    opcode_t                opcode;
    alu_op_t                alu_op;
    a_sel_t                 a_sel;
    b_sel_t                 b_sel;
    wb_sel_t                wb_sel;
    logic [REG_ADDR_W-1:0]  rd;
    logic                   reg_wen;
    logic                   dren;
    logic                   dwen;
    logic                   branch;
    logic                   jump;
    logic                   jalr;
    logic [2:0]             funct3;
    logic [WORD_W-1:0]      imm;
  } ctrl_t;

  typedef struct packed {
    logic [WORD_W-1:0] instr;
    logic [WORD_W-1:0] pc;
  } instr_req_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_wen;
    logic [WORD_W-1:0]     result;
    logic [WORD_W-1:0]     mem_addr;
    logic [3:0]            byte_en;
    logic                  dren;
    logic                  dwen;
    logic                  redirect;
    logic [WORD_W-1:0]     target;
  } exec_rsp_t;

endpackage

`default_nettype wire

// File: control_unit/control_unit.sv
/*
  RV32I control unit
  Combinational decode of one instruction word into the control
  word used by the execute stage: ALU operation, operand and
  write-back selects, register write, memory and control-flow
  flags, plus the sign-extended immediate for the format.
*/

`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  logic [rv32i_pkg::WORD_W-1:0] instr_i,
  output rv32i_pkg::ctrl_t             ctrl_o
);

  rv32i_pkg::itype_t      instr_it;
  rv32i_pkg::stype_t      instr_st;
  rv32i_pkg::rtype_t      instr_rt;
  rv32i_pkg::sbtype_t     instr_sb;
  rv32i_pkg::utype_t      instr_ut;
  rv32i_pkg::ujtype_t     instr_uj;
  rv32i_pkg::opcode_t     opcode;
  rv32i_pkg::alu_funct3_t alu_f3;
  rv32i_pkg::alu_op_t     arith_op;
  logic [rv32i_pkg::WORD_W-1:0] imm_i;
  logic [rv32i_pkg::WORD_W-1:0] imm_s;
  logic [rv32i_pkg::WORD_W-1:0] imm_sb;
  logic [rv32i_pkg::WORD_W-1:0] imm_u;
  logic [rv32i_pkg::WORD_W-1:0] imm_uj;
  logic [rv32i_pkg::WORD_W-1:0] imm_shamt;
  logic                         is_shift;
  rv32i_pkg::ctrl_t             ctrl;

  assign instr_it = rv32i_pkg::itype_t'(instr_i);
  assign instr_st = rv32i_pkg::stype_t'(instr_i);
  assign instr_rt = rv32i_pkg::rtype_t'(instr_i);
  assign instr_sb = rv32i_pkg::sbtype_t'(instr_i);
  assign instr_ut = rv32i_pkg::utype_t'(instr_i);
  assign instr_uj = rv32i_pkg::ujtype_t'(instr_i);

  assign opcode = rv32i_pkg::opcode_t'(instr_i[6:0]);
  assign alu_f3 = rv32i_pkg::alu_funct3_t'(instr_rt.funct3);

  // Sign-extended immediates per format
  assign imm_i  = {{20{instr_it.imm11_00[11]}}, instr_it.imm11_00};
  assign imm_s  = {{20{instr_st.imm11_05[6]}}, instr_st.imm11_05, instr_st.imm04_00};
  assign imm_sb = {{19{instr_sb.imm12}}, instr_sb.imm12, instr_sb.imm11,
                   instr_sb.imm10_05, instr_sb.imm04_01, 1'b0};
  assign imm_uj = {{11{instr_uj.imm20}}, instr_uj.imm20, instr_uj.imm19_12,
                   instr_uj.imm11, instr_uj.imm10_01, 1'b0};
  assign imm_u  = {instr_ut.imm31_12, 12'b0};

  // Shift-immediates carry shamt in the rs2 slot
  assign imm_shamt = {{(rv32i_pkg::WORD_W - rv32i_pkg::REG_ADDR_W){1'b0}}, instr_rt.rs2};
  assign is_shift  = (alu_f3 == rv32i_pkg::SLL) || (alu_f3 == rv32i_pkg::SR);

  // funct7 bit 5 picks SUB and SRA; SUB exists only for reg-reg
  always_comb begin
    case (alu_f3)
      rv32i_pkg::ADDSUB: begin
        if (opcode == rv32i_pkg::REGREG && instr_rt.funct7[5]) begin
          arith_op = rv32i_pkg::ALU_SUB;
        end else begin
          arith_op = rv32i_pkg::ALU_ADD;
        end
      end
      rv32i_pkg::SLL:  arith_op = rv32i_pkg::ALU_SLL;
      rv32i_pkg::SLT:  arith_op = rv32i_pkg::ALU_SLT;
      rv32i_pkg::SLTU: arith_op = rv32i_pkg::ALU_SLTU;
      rv32i_pkg::XOR:  arith_op = rv32i_pkg::ALU_XOR;
      rv32i_pkg::SR:   arith_op = instr_rt.funct7[5] ? rv32i_pkg::ALU_SRA : rv32i_pkg::ALU_SRL;
      rv32i_pkg::OR:   arith_op = rv32i_pkg::ALU_OR;
      rv32i_pkg::AND:  arith_op = rv32i_pkg::ALU_AND;
      default:         arith_op = rv32i_pkg::ALU_ADD;
    endcase
  end

  always_comb begin
    // Safe default, no writes and no redirect
    ctrl        = '0;
    ctrl.opcode = opcode;
    ctrl.funct3 = instr_it.funct3;
    ctrl.alu_op = rv32i_pkg::ALU_ADD;
    ctrl.a_sel  = rv32i_pkg::A_RS1;
    ctrl.b_sel  = rv32i_pkg::B_RS2;
    ctrl.wb_sel = rv32i_pkg::WB_ALU;
    case (opcode)
      rv32i_pkg::LUI: begin
        ctrl.reg_wen = 1'b1;
        ctrl.wb_sel  = rv32i_pkg::WB_UIMM;
        ctrl.imm     = imm_u;
      end
      rv32i_pkg::AUIPC: begin
        ctrl.reg_wen = 1'b1;
        ctrl.a_sel   = rv32i_pkg::A_PC;
        ctrl.b_sel   = rv32i_pkg::B_IMM;
        ctrl.imm     = imm_u;
      end
      rv32i_pkg::JAL: begin
        ctrl.reg_wen = 1'b1;
        ctrl.jump    = 1'b1;
        ctrl.wb_sel  = rv32i_pkg::WB_PC4;
        ctrl.a_sel   = rv32i_pkg::A_PC;
        ctrl.b_sel   = rv32i_pkg::B_IMM;
        ctrl.imm     = imm_uj;
      end
      rv32i_pkg::JALR: begin
        ctrl.reg_wen = 1'b1;
        ctrl.jump    = 1'b1;
        ctrl.jalr    = 1'b1;
        ctrl.wb_sel  = rv32i_pkg::WB_PC4;
        ctrl.b_sel   = rv32i_pkg::B_IMM;
        ctrl.imm     = imm_i;
      end
      rv32i_pkg::BRANCH: begin
        ctrl.branch = 1'b1;
        ctrl.imm    = imm_sb;
      end
      rv32i_pkg::LOAD: begin
        ctrl.reg_wen = 1'b1;
        ctrl.dren    = 1'b1;
        ctrl.b_sel   = rv32i_pkg::B_IMM;
        ctrl.imm     = imm_i;
      end
      rv32i_pkg::STORE: begin
        ctrl.dwen  = 1'b1;
        ctrl.b_sel = rv32i_pkg::B_IMM;
        ctrl.imm   = imm_s;
      end
      rv32i_pkg::IMMED: begin
        ctrl.reg_wen = 1'b1;
        ctrl.alu_op  = arith_op;
        ctrl.b_sel   = rv32i_pkg::B_IMM;
        ctrl.imm     = is_shift ? imm_shamt : imm_i;
      end
      rv32i_pkg::REGREG: begin
        ctrl.reg_wen = 1'b1;
        ctrl.alu_op  = arith_op;
      end
      default: begin
        ctrl.reg_wen = 1'b0;
      end
    endcase
    // rd only meaningful when the register is written
    ctrl.rd = ctrl.reg_wen ? instr_it.rd : '0;
  end

  assign ctrl_o = ctrl;

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
/*
  RV32I register file
  31 writable registers with x0 tied to zero, two combinational
  read ports and one write port. A read of the register written
  in the same cycle returns the new data.
*/

`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic [rv32i_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [rv32i_pkg::REG_ADDR_W-1:0] rs2_i,
  input  logic [rv32i_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic                             wen_i,
  input  logic [rv32i_pkg::WORD_W-1:0]     wdata_i,
  output logic [rv32i_pkg::WORD_W-1:0]     rs1_data_o,
  output logic [rv32i_pkg::WORD_W-1:0]     rs2_data_o
);

  logic [rv32i_pkg::WORD_W-1:0] regs [1:31];
  logic                         wr_live;

  // x0 writes are dropped here as well
  assign wr_live = wen_i && (rd_i != '0);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // Read with write-through bypass
  always_comb begin
    if (rs1_i == '0) begin
      rs1_data_o = '0;
    end else if (wr_live && rd_i == rs1_i) begin
      rs1_data_o = wdata_i;
    end else begin
      rs1_data_o = regs[rs1_i];
    end
  end

  always_comb begin
    if (rs2_i == '0) begin
      rs2_data_o = '0;
    end else if (wr_live && rd_i == rs2_i) begin
      rs2_data_o = wdata_i;
    end else begin
      rs2_data_o = regs[rs2_i];
    end
  end

endmodule

`default_nettype wire

// File: rtl/execute_unit.sv
/*
  RV32I execute stage
  Operand selection, ALU, branch compare, jump target and byte
  enables, followed by a one-entry output register behind a
  valid/ready handshake. An accepted response drives write-back.
*/

`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  logic                             clk,
  input  logic                             reset_i,
  input  rv32i_pkg::ctrl_t                 ctrl_i,
  input  logic [rv32i_pkg::WORD_W-1:0]     pc_i,
  input  logic [rv32i_pkg::WORD_W-1:0]     rs1_data_i,
  input  logic [rv32i_pkg::WORD_W-1:0]     rs2_data_i,
  input  logic                             in_valid_i,
  output logic                             in_ready_o,
  output rv32i_pkg::exec_rsp_t             rsp_o,
  output logic                             rsp_valid_o,
  input  logic                             rsp_ready_i,
  output logic                             wb_wen_o,
  output logic [rv32i_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [rv32i_pkg::WORD_W-1:0]     wb_data_o
);

  logic [rv32i_pkg::WORD_W-1:0] op_a;
  logic [rv32i_pkg::WORD_W-1:0] op_b;
  logic [rv32i_pkg::WORD_W-1:0] alu_out;
  logic [rv32i_pkg::WORD_W-1:0] wb_value;
  logic [rv32i_pkg::WORD_W-1:0] tgt_base;
  logic [rv32i_pkg::WORD_W-1:0] tgt_sum;
  logic [1:0]                   offset;
  logic [3:0]                   byte_en;
  logic                         taken;
  logic                         mem_access;
  logic                         accept;
  rv32i_pkg::exec_rsp_t         rsp_d;
  rv32i_pkg::exec_rsp_t         rsp_q;
  logic                         valid_q;

  assign op_a = (ctrl_i.a_sel == rv32i_pkg::A_PC) ? pc_i : rs1_data_i;
  assign op_b = (ctrl_i.b_sel == rv32i_pkg::B_IMM) ? ctrl_i.imm : rs2_data_i;

  always_comb begin
    case (ctrl_i.alu_op)
      rv32i_pkg::ALU_ADD:  alu_out = op_a + op_b;
      rv32i_pkg::ALU_SUB:  alu_out = op_a - op_b;
      rv32i_pkg::ALU_AND:  alu_out = op_a & op_b;
      rv32i_pkg::ALU_OR:   alu_out = op_a | op_b;
      rv32i_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
      rv32i_pkg::ALU_SLL:  alu_out = op_a << op_b[4:0];
      rv32i_pkg::ALU_SRL:  alu_out = op_a >> op_b[4:0];
      rv32i_pkg::ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
      rv32i_pkg::ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
      rv32i_pkg::ALU_SLTU: alu_out = {31'b0, op_a < op_b};
      default:             alu_out = op_a + op_b;
    endcase
  end

  // Branch condition from funct3
  always_comb begin
    case (rv32i_pkg::branch_t'(ctrl_i.funct3))
      rv32i_pkg::BEQ:  taken = (rs1_data_i == rs2_data_i);
      rv32i_pkg::BNE:  taken = (rs1_data_i != rs2_data_i);
      rv32i_pkg::BLT:  taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
      rv32i_pkg::BGE:  taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      rv32i_pkg::BLTU: taken = (rs1_data_i < rs2_data_i);
      rv32i_pkg::BGEU: taken = (rs1_data_i >= rs2_data_i);
      default:         taken = 1'b0;
    endcase
  end

  // JALR target is rs1 relative with bit 0 cleared
  assign tgt_base = ctrl_i.jalr ? rs1_data_i : pc_i;
  assign tgt_sum  = tgt_base + ctrl_i.imm;

  always_comb begin
    case (ctrl_i.wb_sel)
      rv32i_pkg::WB_PC4:  wb_value = pc_i + 32'd4;
      rv32i_pkg::WB_UIMM: wb_value = ctrl_i.imm;
      default:            wb_value = alu_out;
    endcase
  end

  // Byte lanes from access size and address offset
  assign mem_access = ctrl_i.dren || ctrl_i.dwen;
  assign offset     = alu_out[1:0];

  always_comb begin
    case (rv32i_pkg::load_t'(ctrl_i.funct3))
      rv32i_pkg::LB, rv32i_pkg::LBU: byte_en = 4'b0001 << offset;
      rv32i_pkg::LH, rv32i_pkg::LHU: begin
        case (offset)
          2'b00:   byte_en = 4'b0011;
          2'b10:   byte_en = 4'b1100;
          default: byte_en = 4'b0000;
        endcase
      end
      rv32i_pkg::LW: byte_en = (offset == 2'b00) ? 4'b1111 : 4'b0000;
      default:       byte_en = 4'b0000;
    endcase
  end

  always_comb begin
    rsp_d          = '0;
    rsp_d.rd       = ctrl_i.rd;
    rsp_d.reg_wen  = ctrl_i.reg_wen;
    rsp_d.result   = wb_value;
    rsp_d.dren     = ctrl_i.dren;
    rsp_d.dwen     = ctrl_i.dwen;
    rsp_d.redirect = ctrl_i.jump || (ctrl_i.branch && taken);
    if (mem_access) begin
      rsp_d.mem_addr = alu_out;
      rsp_d.byte_en  = byte_en;
    end
    if (rsp_d.redirect) begin
      rsp_d.target = ctrl_i.jalr ? {tgt_sum[31:1], 1'b0} : tgt_sum;
    end
  end

  // One-entry output stage, refills in the cycle it drains
  assign in_ready_o = !valid_q || rsp_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = valid_q;

  // Write back only on the output handshake
  assign wb_wen_o  = valid_q && rsp_ready_i && rsp_q.reg_wen && (rsp_q.rd != '0);
  assign wb_rd_o   = rsp_q.rd;
  assign wb_data_o = rsp_q.result;

endmodule

`default_nettype wire

// File: rtl/rv32i_decode_exec.sv
/*
  RV32I decode and execute slice
  Control unit and register file work side by side on the
  incoming instruction; the execute stage combines them and
  returns accepted results to the register file.
*/

`timescale 1ns/1ps
`default_nettype none

module rv32i_decode_exec (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  rv32i_pkg::instr_req_t req_i,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output rv32i_pkg::exec_rsp_t  rsp_o
);

  rv32i_pkg::ctrl_t                 ctrl;
  logic [rv32i_pkg::WORD_W-1:0]     rs1_data;
  logic [rv32i_pkg::WORD_W-1:0]     rs2_data;
  logic                             wb_wen;
  logic [rv32i_pkg::REG_ADDR_W-1:0] wb_rd;
  logic [rv32i_pkg::WORD_W-1:0]     wb_data;

  control_unit u_control_unit (
    .instr_i (req_i.instr),
    .ctrl_o  (ctrl)
  );

  // Source indices straight from the instruction word
  reg_file u_reg_file (
    .clk        (clk),
    .reset_i    (reset_i),
    .rs1_i      (req_i.instr[19:15]),
    .rs2_i      (req_i.instr[24:20]),
    .rd_i       (wb_rd),
    .wen_i      (wb_wen),
    .wdata_i    (wb_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  execute_unit u_execute_unit (
    .clk         (clk),
    .reset_i     (reset_i),
    .ctrl_i      (ctrl),
    .pc_i        (req_i.pc),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .wb_wen_o    (wb_wen),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data)
  );

endmodule

`default_nettype wire

// File: dv/rv32i_decode_exec_assertions.sv
/*
  Handshake and reset assertions for the decode and execute slice
*/

`timescale 1ns/1ps
`default_nettype none

module rv32i_decode_exec_assertions (
  input logic                 clk,
  input logic                 reset_i,
  input logic                 req_valid_i,
  input logic                 req_ready_o,
  input logic                 rsp_valid_o,
  input logic                 rsp_ready_i,
  input rv32i_pkg::exec_rsp_t rsp_o
);

  // Stalled response holds its payload
  assert property (@(posedge clk) disable iff (reset_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else $error("rsp_o changed while stalled");

  assert property (@(posedge clk) reset_i |=> !rsp_valid_o)
    else $error("rsp_valid_o high after reset");

  // One cycle latency into an empty output stage
  assert property (@(posedge clk) disable iff (reset_i)
    req_valid_i && req_ready_o && !rsp_valid_o |=> rsp_valid_o)
    else $error("rsp_valid_o did not rise after request");

endmodule

bind rv32i_decode_exec rv32i_decode_exec_assertions u_rv32i_decode_exec_assertions (
  .clk         (clk),
  .reset_i     (reset_i),
  .req_valid_i (req_valid_i),
  .req_ready_o (req_ready_o),
  .rsp_valid_o (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i),
  .rsp_o       (rsp_o)
);

`default_nettype wire

// File: dv/tb_rv32i_decode_exec.sv
/*
  Testbench for the RV32I decode and execute slice
  Reads instructions and expected responses from a stimulus file,
  drives the request side, applies back-pressure on the response
  side and checks every accepted response in order.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_rv32i_decode_exec;

  logic                  clk;
  logic                  reset_i;
  logic                  req_valid_i;
  logic                  req_ready_o;
  rv32i_pkg::instr_req_t req_i;
  logic                  rsp_valid_o;
  logic                  rsp_ready_i;
  rv32i_pkg::exec_rsp_t  rsp_o;

  rv32i_pkg::instr_req_t req_q[$];
  rv32i_pkg::exec_rsp_t  exp_q[$];
  int                    hold_q[$];
  int                    err_count;
  int                    test_count;
  int                    cycle_count;
  int                    cycle_limit;
  bit                    test_bad;

  rv32i_decode_exec u_rv32i_decode_exec (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("CHECK FAILED %s exp %h got %h", name, exp, got);
      err_count++;
      test_bad = 1'b1;
    end
  endtask

  // Lines starting with # are column notes
  task automatic load_stimulus();
    int                   fd;
    int                   max_hold;
    string                line;
    logic [31:0]          f [12];
    rv32i_pkg::exec_rsp_t exp;
    fd = $fopen("dv/decode_exec_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open stimulus file dv/decode_exec_stim.txt");
    end else begin
      max_hold = 0;
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          void'($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]));
          exp          = '0;
          exp.rd       = f[3][4:0];
          exp.reg_wen  = f[4][0];
          exp.result   = f[5];
          exp.mem_addr = f[6];
          exp.byte_en  = f[7][3:0];
          exp.dren     = f[8][0];
          exp.dwen     = f[9][0];
          exp.redirect = f[10][0];
          exp.target   = f[11];
          req_q.push_back('{instr: f[0], pc: f[1]});
          hold_q.push_back(int'(f[2]));
          exp_q.push_back(exp);
          if (int'(f[2]) > max_hold) begin
            max_hold = int'(f[2]);
          end
        end
      end
      $fclose(fd);
      cycle_limit = req_q.size() * (2 + max_hold) + 20;
    end
  endtask

  task automatic drive_requests();
    int idle;
    @(posedge clk);
    foreach (req_q[i]) begin
      idle = ($urandom % 4 == 0) ? 1 : 0;
      if (idle > 0) begin
        req_valid_i <= 1'b0;
        repeat (idle) @(posedge clk);
      end
      req_valid_i <= 1'b1;
      req_i       <= req_q[i];
      do @(negedge clk); while (!req_ready_o);
      @(posedge clk);
    end
    req_valid_i <= 1'b0;
  endtask

  task automatic collect_responses();
    rv32i_pkg::exec_rsp_t snap;
    rv32i_pkg::exec_rsp_t exp;
    foreach (exp_q[i]) begin
      exp      = exp_q[i];
      test_bad = 1'b0;
      rsp_ready_i <= (hold_q[i] == 0);
      do @(negedge clk); while (!rsp_valid_o);
      snap = rsp_o;
      // Held response must not move and the input must stall
      for (int h = 0; h < hold_q[i]; h++) begin
        check_word("req_ready_o", 32'h0, {31'b0, req_ready_o});
        @(posedge clk);
        if (h == hold_q[i] - 1) begin
          rsp_ready_i <= 1'b1;
        end
        @(negedge clk);
        assert (rsp_o === snap) else begin
          $display("CHECK FAILED rsp_o exp %h got %h", snap, rsp_o);
          err_count++;
          test_bad = 1'b1;
        end
      end
      check_word("rd", {27'b0, exp.rd}, {27'b0, rsp_o.rd});
      check_word("reg_wen", {31'b0, exp.reg_wen}, {31'b0, rsp_o.reg_wen});
      check_word("result", exp.result, rsp_o.result);
      check_word("mem_addr", exp.mem_addr, rsp_o.mem_addr);
      check_word("byte_en", {28'b0, exp.byte_en}, {28'b0, rsp_o.byte_en});
      check_word("dren", {31'b0, exp.dren}, {31'b0, rsp_o.dren});
      check_word("dwen", {31'b0, exp.dwen}, {31'b0, rsp_o.dwen});
      check_word("redirect", {31'b0, exp.redirect}, {31'b0, rsp_o.redirect});
      check_word("target", exp.target, rsp_o.target);
      test_count++;
      $display("test %0d instr %h pc %h: %s", i, req_q[i].instr, req_q[i].pc,
               test_bad ? "mismatch" : "ok");
      @(posedge clk);
    end
  endtask

  // Run limit scales with the number of lines and the longest stall
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("run timed out after %0d cycles", cycle_count);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(41171));
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b1;
    err_count   = 0;
    test_count  = 0;
    cycle_count = 0;
    cycle_limit = 0;
    test_bad    = 1'b0;
    load_stimulus();
    if (req_q.size() == 0) begin
      $display("no stimulus lines were loaded");
      $display("test failed");
    end else begin
      repeat (2) @(posedge clk);
      reset_i <= 1'b0;
      @(negedge clk);
      check_word("rsp_valid_o", 32'h0, {31'b0, rsp_valid_o});
      @(posedge clk);
      fork
        drive_requests();
        collect_responses();
      join
      // Nothing may come out after the last expected response
      @(negedge clk);
      check_word("rsp_valid_o", 32'h0, {31'b0, rsp_valid_o});
      $display("%0d tests run, %0d errors", test_count, err_count);
      if (err_count == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/decode_exec_stim.txt
# instr pc hold rd reg_wen result mem_addr byte_en dren dwen redirect target
# all hex, hold is the number of cycles rsp_ready_i stays low
01f100b3 00000100 0 01 1 00000000 00000000 0 0 0 0 00000000
7ff00093 00000104 0 01 1 000007ff 00000000 0 0 0 0 00000000
ff800113 00000108 0 02 1 fffffff8 00000000 0 0 0 0 00000000
123451b7 0000010c 0 03 1 12345000 00000000 0 0 0 0 00000000
00001217 00000110 0 04 1 00001110 00000000 0 0 0 0 00000000
002082b3 00000114 0 05 1 000007f7 00000000 0 0 0 0 00000000
40128333 00000118 0 06 1 fffffff8 00000000 0 0 0 0 00000000
0041f3b3 0000011c 3 07 1 00001000 00000000 0 0 0 0 00000000
0041e433 00000120 0 08 1 12345110 00000000 0 0 0 0 00000000
0020c4b3 00000124 1 09 1 fffff807 00000000 0 0 0 0 00000000
00400593 00000128 0 0b 1 00000004 00000000 0 0 0 0 00000000
00b09533 0000012c 0 0a 1 00007ff0 00000000 0 0 0 0 00000000
00b15633 00000130 0 0c 1 0fffffff 00000000 0 0 0 0 00000000
40b156b3 00000134 2 0d 1 ffffffff 00000000 0 0 0 0 00000000
00112733 00000138 0 0e 1 00000001 00000000 0 0 0 0 00000000
001137b3 0000013c 0 0f 1 00000000 00000000 0 0 0 0 00000000
00118803 00000140 0 10 1 12345001 12345001 2 1 0 0 00000000
0031c803 00000144 0 10 1 12345003 12345003 8 1 0 0 00000000
00219883 00000148 0 11 1 12345002 12345002 c 1 0 0 00000000
0011d883 0000014c 0 11 1 12345001 12345001 0 1 0 0 00000000
0001a903 00000150 2 12 1 12345000 12345000 f 1 0 0 00000000
0011a323 00000154 0 00 0 12345006 12345006 0 0 1 0 00000000
00119123 00000158 0 00 0 12345002 12345002 c 0 1 0 00000000
00118023 0000015c 0 00 0 12345000 12345000 1 0 1 0 00000000
00108863 00000200 0 00 0 00000ffe 00000000 0 0 0 1 00000210
00109863 00000200 0 00 0 00000ffe 00000000 0 0 0 0 00000000
00114863 00000200 0 00 0 000007f7 00000000 0 0 0 1 00000210
00115863 00000200 0 00 0 000007f7 00000000 0 0 0 0 00000000
00116863 00000200 0 00 0 000007f7 00000000 0 0 0 0 00000000
00117863 00000200 0 00 0 000007f7 00000000 0 0 0 1 00000210
00208863 00000200 0 00 0 000007f7 00000000 0 0 0 0 00000000
00209863 00000200 0 00 0 000007f7 00000000 0 0 0 1 00000210
0020c863 00000200 0 00 0 000007f7 00000000 0 0 0 0 00000000
0020d863 00000200 0 00 0 000007f7 00000000 0 0 0 1 00000210
0020e863 00000200 0 00 0 000007f7 00000000 0 0 0 1 00000210
0020f863 00000200 0 00 0 000007f7 00000000 0 0 0 0 00000000
020009ef 00000300 4 13 1 00000304 00000000 0 0 0 1 00000320
00520a67 00000400 0 14 1 00000404 00000000 0 0 0 1 00001114
ff9ff06f 00000500 1 00 1 00000504 00000000 0 0 0 1 000004f8
00000ab3 00000504 0 15 1 00000000 00000000 0 0 0 0 00000000

// File: vlog.f
common/rv32i_pkg.sv
control_unit/control_unit.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/rv32i_decode_exec.sv
dv/rv32i_decode_exec_assertions.sv
dv/tb_rv32i_decode_exec.sv

// File: Makefile
TOP := tb_rv32i_decode_exec

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "test passed"

clean:
	rm -rf obj_dir
